/* tx_pulse_filter.f */
+incdir+test
common/fir_sample_pkg.sv
common/fir_coeff_pkg.sv
filter/tap_delay_line.sv
filter/tap_product_stage.sv
filter/adder_tree.sv
logic/tx_pulse_filter.sv
test/tb_tx_pulse_filter.sv

/* test/tb_filter_model.svh */
`ifndef TB_FILTER_MODEL_SVH
`define TB_FILTER_MODEL_SVH

// Samples accepted on enables since reset, oldest first
sample_t accepted [$];

function automatic void clear_history();
	accepted.delete();
endfunction

function automatic void record_sample(sample_t x);
	accepted.push_back(x);
endfunction

// Tap i once the given number of samples has been taken
function automatic longint tap_value(int taken, int i);
	int idx;
	idx = taken - 1 - i;
	if (idx < 0)
		return 0;
	return longint'(accepted[idx]);
endfunction

// Coefficient times the fold sum, zero unless the sum is a listed level multiple
function automatic longint fold_product(longint coeff, longint fold_sum, bit center);
	longint m;
	longint m_abs;
	sample_t kept;
	if (fold_sum % LEVEL_UNIT != 0)
		return 0;
	m = fold_sum / LEVEL_UNIT;
	m_abs = (m < 0) ? -m : m;
	if (center && m_abs != 1 && m_abs != 3)
		return 0;
	if (!center && m_abs > 4 && m_abs != 6)
		return 0;
	kept = sample_t'((coeff * fold_sum) >>> PRODUCT_SHIFT);
	return longint'(kept);
endfunction

// y after the given enable count since reset, two enables behind the taps
function automatic sample_t expected_y(int enables);
	longint total;
	int n;
	if (enables <= 2)
		return '0;
	n = enables - 2;
	total = 0;
	for (int i = 0; i < HALF_TAPS; i++)
		total += fold_product(COEFFS[i], tap_value(n, i) + tap_value(n, TAP_COUNT - 1 - i), 0);
	total += fold_product(COEFFS[HALF_TAPS], tap_value(n, HALF_TAPS), 1);
	// Sum wraps at 18 bits
	return sample_t'(total);
endfunction

`endif

/* test/tb_tx_pulse_filter.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_tx_pulse_filter;

	import fir_sample_pkg::*;
	import fir_coeff_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int FLUSH_LEN = 3;
	localparam int RANDOM_ENABLES = 200;
	localparam int GAP_ENABLES = 60;
	localparam int MAX_GAP = 3;
	localparam int OFF_LEVEL_ENABLES = 100;
	localparam int TEST_CYCLES = (RESET_CYCLES + 3) + (TAP_COUNT + 4) + RANDOM_ENABLES
		+ GAP_ENABLES * (MAX_GAP + 1) + OFF_LEVEL_ENABLES + 5 * FLUSH_LEN;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

	logic clk = 1'b0;
	logic reset;
	logic sam_clk_en;
	sample_t x_in;
	sample_t y;

	int enable_count = 0;
	bit enabled_now = 0;
	sample_t held_y = '0;
	sample_t y_log [$];
	string test_name = "reset";
	int test_errors = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int cycle_count = 0;

	`include "tb_filter_model.svh"

	tx_pulse_filter u_dut (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.y          (y)
	);

	always #50 clk = ~clk;

	// Records each accepted sample and clears with the DUT on reset
	always @(posedge clk)
	begin
		if (reset)
		begin
			clear_history();
			y_log.delete();
			enable_count = 0;
			enabled_now = 0;
		end
		else if (sam_clk_en)
		begin
			record_sample(x_in);
			enable_count++;
			enabled_now = 1;
		end
		else
			enabled_now = 0;
	end

	// Compare y with the model once per cycle
	always @(negedge clk)
	begin
		sample_t want;
		if (reset)
			want = '0;
		else if (enabled_now)
			want = expected_y(enable_count);
		else
			want = held_y;
		check_count++;
		assert (y == want)
		else
		begin
			$display("** Error %s: y expected %0d, actual %0d", test_name, want, y);
			error_count++;
			test_errors++;
		end
		if (!reset && enabled_now)
			y_log.push_back(y);
		held_y = y;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	task automatic drive(input logic en, input sample_t x);
		@(posedge clk);
		#1;
		sam_clk_en = en;
		x_in = x;
	endtask

	// Push the last samples through both pipeline registers
	task automatic flush_pipeline();
		drive(1'b1, '0);
		drive(1'b1, '0);
		drive(1'b0, '0);
		@(negedge clk);
		#1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic report_test();
		test_count++;
		if (test_errors == 0)
			$display("Test %s: passed", test_name);
		else
		begin
			$display("Test %s: failed with %0d errors", test_name, test_errors);
			failed_tests++;
		end
	endtask

	function automatic sample_t random_pam4_sample();
		int level;
		level = 2 * int'($urandom % 4) - 3;
		return sample_t'(level * LEVEL_UNIT);
	endfunction

	function automatic sample_t off_level_sample();
		case ($urandom % 4)
			0: return sample_t'(1000);
			1: return sample_t'(-LEVEL_UNIT / 2);
			2: return sample_t'(2 * LEVEL_UNIT);
			default: return sample_t'($urandom);
		endcase
	endfunction

	// A +3-unit impulse meets each coefficient alone, so y is 3/4 of it
	function automatic sample_t impulse_response(int j);
		int f;
		f = (j <= HALF_TAPS) ? j : TAP_COUNT - 1 - j;
		return sample_t'((3 * longint'(COEFFS[f])) >>> 2);
	endfunction

	initial
	begin
		int k0;
		int idle;
		sample_t want;

		void'($urandom(60122));
		reset = 1'b1;
		sam_clk_en = 1'b1;
		x_in = sample_t'(3 * LEVEL_UNIT);

		// Enables during reset must be ignored
		start_test("reset");
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		x_in = '0;
		drive(1'b1, '0);
		drive(1'b1, '0);
		flush_pipeline();
		report_test();

		start_test("impulse");
		k0 = enable_count + 1;
		drive(1'b1, sample_t'(3 * LEVEL_UNIT));
		repeat (TAP_COUNT + 1) drive(1'b1, '0);
		flush_pipeline();
		for (int j = 0; j < TAP_COUNT; j++)
		begin
			want = impulse_response(j);
			check_count++;
			assert (y_log[k0 + 1 + j] == want)
			else
			begin
				$display("** Error %s: y[%0d] expected %0d, actual %0d", test_name, j, want,
					y_log[k0 + 1 + j]);
				error_count++;
				test_errors++;
			end
		end
		report_test();

		start_test("random_pam4");
		repeat (RANDOM_ENABLES) drive(1'b1, random_pam4_sample());
		flush_pipeline();
		report_test();

		// Idle cycles carry junk on x_in
		start_test("enable_gaps");
		repeat (GAP_ENABLES)
		begin
			idle = $urandom % (MAX_GAP + 1);
			repeat (idle) drive(1'b0, random_pam4_sample());
			drive(1'b1, random_pam4_sample());
		end
		flush_pipeline();
		report_test();

		start_test("off_level");
		repeat (OFF_LEVEL_ENABLES)
		begin
			if ($urandom % 3 == 0)
				drive(1'b1, off_level_sample());
			else
				drive(1'b1, random_pam4_sample());
		end
		flush_pipeline();
		report_test();

		$display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d", test_count,
			failed_tests, check_count, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/tx_pulse_filter.sv */
`default_nettype none
`timescale 1ns/1ps

module tx_pulse_filter (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input fir_sample_pkg::sample_t x_in,
	output fir_sample_pkg::sample_t y
);

	import fir_sample_pkg::*;
	import fir_coeff_pkg::*;

	// Folded pair sums, combinational from the taps
	presum_t presum [FOLD_COUNT];

	// Registered lookup products
	sample_t product [FOLD_COUNT];

	tap_delay_line u_tap_delay_line (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.x_in       (x_in),
		.presum     (presum)
	);

	// Adds one enable of latency
	tap_product_stage u_tap_product_stage (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.presum     (presum),
		.product    (product)
	);

	// y lands two enables after the sample enters tap 0
	adder_tree u_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.sam_clk_en (sam_clk_en),
		.product    (product),
		.y          (y)
	);

endmodule

`default_nettype wire

/* filter/adder_tree.sv */
`default_nettype none
`timescale 1ns/1ps

module adder_tree (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input fir_sample_pkg::sample_t product [fir_coeff_pkg::FOLD_COUNT],
	output fir_sample_pkg::sample_t y
);

	import fir_sample_pkg::*;
	import fir_coeff_pkg::*;

	// Row 0 is the products, the last row holds the total in entry 0
	// Entries past a row's width stay zero
	sample_t level_sum [TREE_DEPTH+1][FOLD_COUNT];

	always_comb
	begin
		int width_below;

		for (int j = 0; j < FOLD_COUNT; j++)
		begin
			level_sum[0][j] = product[j];
		end

		for (int l = 1; l <= TREE_DEPTH; l++)
		begin
			width_below = tree_width(l - 1);
			for (int j = 0; j < FOLD_COUNT; j++)
			begin
				if (2 * j + 1 < width_below)
				begin
					// 18-bit add, overflow wraps
					level_sum[l][j] = level_sum[l-1][2*j] + level_sum[l-1][2*j+1];
				end
				else if (2 * j < width_below)
				begin
					// Odd one out moves up unchanged
					level_sum[l][j] = level_sum[l-1][2*j];
				end
				else
				begin
					level_sum[l][j] = '0;
				end
			end
		end
	end

	// Output only changes on an enable
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			y <= '0;
		end
		else if (sam_clk_en)
		begin
			y <= level_sum[TREE_DEPTH][0];
		end
	end

endmodule

`default_nettype wire

/* filter/tap_product_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module tap_product_stage (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input fir_sample_pkg::presum_t presum [fir_coeff_pkg::FOLD_COUNT],
	output fir_sample_pkg::sample_t product [fir_coeff_pkg::FOLD_COUNT]
);

	import fir_sample_pkg::*;
	import fir_coeff_pkg::*;

	sample_t lut_out [FOLD_COUNT];

	// Coefficient times a whole multiple of LEVEL_UNIT, back in 1s17
	// Both arguments are constant per fold, so this folds to a table entry
	function automatic sample_t scale_coeff(coeff_t coeff, int multiple);
		logic signed [SAMPLE_WIDTH+PRESUM_WIDTH-1:0] full;
		full = coeff * (multiple * LEVEL_UNIT);
		return sample_t'(full >>> PRODUCT_SHIFT);
	endfunction

	// Pair sums of two PAM-4 levels land on 0, +-2, +-4 or +-6 units
	// A pair with one zero tap (start-up) gives +-1 or +-3 units
	// The lone center tap can only be +-1 or +-3 units
	function automatic sample_t lookup_product(coeff_t coeff, presum_t level_sum,
		logic center);
		sample_t result;
		result = '0;
		case (level_sum)
			presum_t'(0):
				result = '0;
			presum_t'(LEVEL_UNIT):
				result = scale_coeff(coeff, 1);
			presum_t'(-LEVEL_UNIT):
				result = scale_coeff(coeff, -1);
			presum_t'(3 * LEVEL_UNIT):
				result = scale_coeff(coeff, 3);
			presum_t'(-3 * LEVEL_UNIT):
				result = scale_coeff(coeff, -3);
			presum_t'(2 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, 2);
			presum_t'(-2 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, -2);
			presum_t'(4 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, 4);
			presum_t'(-4 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, -4);
			presum_t'(6 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, 6);
			presum_t'(-6 * LEVEL_UNIT):
				if (!center)
					result = scale_coeff(coeff, -6);
			// Off-level input contributes nothing
			default:
				result = '0;
		endcase
		return result;
	endfunction

	for (genvar i = 0; i < FOLD_COUNT; i++)
	begin : g_fold
		assign lut_out[i] = lookup_product(COEFFS[i], presum[i], i == HALF_TAPS);
	end

	// One set of products in flight between the delay line and the tree
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < FOLD_COUNT; i++)
			begin
				product[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			for (int i = 0; i < FOLD_COUNT; i++)
			begin
				product[i] <= lut_out[i];
			end
		end
	end

endmodule

`default_nettype wire

/* filter/tap_delay_line.sv */
`default_nettype none
`timescale 1ns/1ps

module tap_delay_line (
	input logic clk,
	input logic reset,
	input logic sam_clk_en,
	input fir_sample_pkg::sample_t x_in,
	output fir_sample_pkg::presum_t presum [fir_coeff_pkg::FOLD_COUNT]
);

	import fir_sample_pkg::*;
	import fir_coeff_pkg::*;

	// Tap 0 holds the newest sample
	sample_t taps [TAP_COUNT];

	// Newest sample in at the enable
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			taps[0] <= '0;
		end
		else if (sam_clk_en)
		begin
			taps[0] <= x_in;
		end
	end

	// Older samples move one tap along
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 1; i < TAP_COUNT; i++)
			begin
				taps[i] <= '0;
			end
		end
		else if (sam_clk_en)
		begin
			for (int i = 1; i < TAP_COUNT; i++)
			begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// Mirrored taps share a coefficient, so add them before the lookup
	always_comb
	begin
		for (int i = 0; i < HALF_TAPS; i++)
		begin
			presum[i] = presum_t'(taps[i]) + presum_t'(taps[TAP_COUNT-1-i]);
		end

		// Center tap has no partner
		presum[HALF_TAPS] = presum_t'(taps[HALF_TAPS]);
	end

endmodule

`default_nettype wire

/* common/fir_coeff_pkg.sv */
`default_nettype none

package fir_coeff_pkg;

	localparam int TAP_COUNT = 21;

	// Mirrored pairs, and the index of the center tap
	localparam int HALF_TAPS = (TAP_COUNT - 1) / 2;

	// Pairs plus the lone center term
	localparam int FOLD_COUNT = HALF_TAPS + 1;

	// Levels of the pairwise adder tree over the folds
	localparam int TREE_DEPTH = $clog2(FOLD_COUNT);

	typedef logic signed [fir_sample_pkg::SAMPLE_WIDTH-1:0] coeff_t;

	// Raised-cosine-like pulse in 1s17, four samples per symbol
	// Entry 0 belongs to the outermost pair, the last entry to the center tap
	// Near-zero values sit at the symbol crossings
	localparam coeff_t COEFFS [FOLD_COUNT] = '{
		655,
		1049,
		393,
		-1966,
		-4588,
		-5243,
		-1311,
		10486,
		33423,
		55706,
		65536
	};

	// Number of live terms at a given tree level
	// An odd leftover is carried up, so each level rounds up
	function automatic int tree_width(int level);
		int width;
		width = FOLD_COUNT;
		for (int l = 0; l < level; l++)
		begin
			width = (width + 1) / 2;
		end
		return width;
	endfunction

endpackage

`default_nettype wire

/* common/fir_sample_pkg.sv */
`default_nettype none

package fir_sample_pkg;

	// Sample format is 1s17
	localparam int SAMPLE_WIDTH = 18;

	// A folded pair sum needs one more integer bit (2s17)
	localparam int PRESUM_WIDTH = 19;

	// 0.25 in 1s17
	// PAM-4 symbols arrive as +-1 and +-3 of these units
	localparam int LEVEL_UNIT = 32768;

	// Coefficient times pre-sum carries 34 fraction bits
	// Shifting by the coefficient's fraction bits leaves 1s17
	localparam int PRODUCT_SHIFT = 17;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	typedef logic signed [PRESUM_WIDTH-1:0] presum_t;

endpackage

`default_nettype wire
